/* lsu_pkg.sv */
package lsu_pkg;

	// Core byte address and data widths
	localparam int unsigned ADDR_W = 13;
	localparam int unsigned DATA_W = 32;
	// Word address seen by the data memory
	localparam int unsigned WORD_AW = ADDR_W - 2;

	// Bit 3 marks a store, bit 2 marks an unsigned load
	// Low two bits give the access size
	typedef enum logic [3:0] {
		LB  = 4'b0000,
		LH  = 4'b0001,
		LW  = 4'b0010,
		LBU = 4'b0100,
		LHU = 4'b0101,
		SB  = 4'b1000,
		SH  = 4'b1001,
		SW  = 4'b1010
	} mem_op_e;

	// Request from the core, one per strobe
	typedef struct packed {
		mem_op_e           op;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
		logic [4:0]        rd;
	} mem_req_t;

	// Load or fault response back to the core
	typedef struct packed {
		logic [DATA_W-1:0] rdata;
		logic [4:0]        rd;
		logic              fault;
	} mem_rsp_t;

	// Stage 1 to stage 2
	typedef struct packed {
		logic [WORD_AW-1:0] word_addr;
		logic [3:0]         be;
		logic [DATA_W-1:0]  wdata;
		logic               is_load;
		mem_op_e            op;
		logic [1:0]         byte_off;
		logic [4:0]         rd;
		logic               fault;
	} align_stage_t;

	// Stage 2 to stage 3, read word travels beside it
	typedef struct packed {
		mem_op_e    op;
		logic [1:0] byte_off;
		logic [4:0] rd;
		logic       fault;
	} mem_stage_t;

endpackage

/* dmem_map_pkg.sv */
package dmem_map_pkg;

	// On-chip RAM geometry
	localparam int unsigned RAM_WORDS = 1024;
	localparam int unsigned RAM_AW    = $clog2(RAM_WORDS);

	// Board I/O word addresses
	// Byte addresses 0x1000, 0x1004 and 0x1008
	localparam logic [lsu_pkg::WORD_AW-1:0] IO_BTN_WA = 'h400;
	localparam logic [lsu_pkg::WORD_AW-1:0] IO_SW_WA  = 'h401;
	localparam logic [lsu_pkg::WORD_AW-1:0] IO_LED_WA = 'h402;

	// Board I/O widths
	// Switches share the button width
	localparam int unsigned LED_W = 4;
	localparam int unsigned BTN_W = 4;

	// Protocol controller access
	// RAM only, word addressed
	// A zero be means a plain read
	typedef struct packed {
		logic [3:0]                be;
		logic [RAM_AW-1:0]         addr;
		logic [lsu_pkg::DATA_W-1:0] wdata;
	} con_req_t;

endpackage

/* store_align.sv */
`timescale 1ns/1ps

module store_align (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 req_en,
	input  lsu_pkg::mem_req_t    req,
	output logic                 align_valid,
	output lsu_pkg::align_stage_t align
);
	import lsu_pkg::*;

	logic [1:0]        off;
	logic [3:0]        be_next;
	logic [DATA_W-1:0] wdata_next;
	logic              is_load_next;
	logic              misalign;
	logic              bad_op;
	logic              fault_next;

	assign off = req.addr[1:0];

	// Size decode, lane enables and store data replication
	always_comb begin
		be_next    = '0;
		wdata_next = req.wdata;
		misalign   = 1'b0;
		bad_op     = 1'b0;
		unique case (req.op)
			LB, LBU, SB: begin
				be_next    = 4'b0001 << off;
				wdata_next = {4{req.wdata[7:0]}};
			end
			LH, LHU, SH: begin
				// Halfword must sit on an even address
				misalign   = off[0];
				be_next    = off[1] ? 4'b1100 : 4'b0011;
				wdata_next = {2{req.wdata[15:0]}};
			end
			LW, SW: begin
				misalign = |off;
				be_next  = 4'b1111;
			end
			default: bad_op = 1'b1;
		endcase
		// Unknown opcodes come back as faulted loads
		is_load_next = !(req.op inside {SB, SH, SW});
		fault_next   = misalign | bad_op;
		// Faulted access must not touch any lane
		if (fault_next)
			be_next = '0;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			align_valid <= 1'b0;
		else
			align_valid <= req_en;
	end

	// Payload only captured on a request
	always_ff @(posedge clk) begin
		if (req_en) begin
			align.word_addr <= req.addr[ADDR_W-1:2];
			align.be        <= be_next;
			align.wdata     <= wdata_next;
			align.is_load   <= is_load_next;
			align.op        <= req.op;
			align.byte_off  <= off;
			align.rd        <= req.rd;
			align.fault     <= fault_next;
		end
	end

	// Only legal lane patterns leave this stage
	a_be_shape: assert property (@(posedge clk) disable iff (!rst_n)
		align_valid |-> ($onehot0(align.be) || align.be == 4'b0011 ||
			align.be == 4'b1100 || align.be == 4'b1111));

endmodule

/* data_mem.sv */
`timescale 1ns/1ps

module data_mem (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          align_valid,
	input  lsu_pkg::align_stage_t         align,
	input  logic [dmem_map_pkg::BTN_W-1:0] btn,
	input  logic [dmem_map_pkg::BTN_W-1:0] sw,
	input  logic                          con_en,
	input  dmem_map_pkg::con_req_t        con_req,
	output logic [lsu_pkg::DATA_W-1:0]    con_rdata,
	output logic                          mem_valid,
	output lsu_pkg::mem_stage_t           mem,
	output logic [lsu_pkg::DATA_W-1:0]    mem_rdata,
	output logic [dmem_map_pkg::LED_W-1:0] led
);
	import lsu_pkg::*;
	import dmem_map_pkg::*;

	logic [DATA_W-1:0] ram [RAM_WORDS];
	logic [DATA_W-1:0] ram_rdata_a;
	logic [RAM_AW-1:0] ram_addr_a;

	logic [BTN_W-1:0]  btn_reg;
	logic [BTN_W-1:0]  sw_reg;
	logic [DATA_W-1:0] led_reg;

	logic              io_hit;
	logic [DATA_W-1:0] io_rdata;
	logic [DATA_W-1:0] io_rdata_q;
	logic              io_sel_q;

	logic              core_we;
	logic              ram_we_a;
	logic              led_we;
	logic              con_we;

	// Words above the I/O block alias onto RAM
	assign ram_addr_a = align.word_addr[RAM_AW-1:0];

	// Only the three I/O words leave the RAM path
	assign io_hit = align.word_addr inside {IO_BTN_WA, IO_SW_WA, IO_LED_WA};

	assign core_we  = align_valid && !align.is_load && !align.fault;
	assign ram_we_a = core_we && !io_hit;
	assign led_we   = core_we && (align.word_addr == IO_LED_WA);
	assign con_we   = con_en && (con_req.be != 4'b0000);

	// True dual-port RAM with read-before-write on both ports
	always_ff @(posedge clk) begin
		if (ram_we_a) begin
			for (int i = 0; i < 4; i++) begin
				if (align.be[i])
					ram[ram_addr_a][8*i +: 8] <= align.wdata[8*i +: 8];
			end
		end
		if (con_we) begin
			for (int i = 0; i < 4; i++) begin
				if (con_req.be[i])
					ram[con_req.addr][8*i +: 8] <= con_req.wdata[8*i +: 8];
			end
		end
		ram_rdata_a <= ram[ram_addr_a];
		// Controller read word holds until its next access
		if (con_en)
			con_rdata <= ram[con_req.addr];
	end

	// Buttons and switches sampled every edge
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			btn_reg <= '0;
			sw_reg  <= '0;
		end else begin
			btn_reg <= btn;
			sw_reg  <= sw;
		end
	end

	// LED register merges the enabled byte lanes
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			led_reg <= '0;
		end else if (led_we) begin
			for (int i = 0; i < 4; i++) begin
				if (align.be[i])
					led_reg[8*i +: 8] <= align.wdata[8*i +: 8];
			end
		end
	end

	assign led = led_reg[LED_W-1:0];

	// I/O read value with board inputs zero-extended
	always_comb begin
		unique case (align.word_addr)
			IO_BTN_WA: io_rdata = {{(DATA_W-BTN_W){1'b0}}, btn_reg};
			IO_SW_WA:  io_rdata = {{(DATA_W-BTN_W){1'b0}}, sw_reg};
			default:   io_rdata = led_reg;
		endcase
	end

	// I/O read registered beside the RAM output
	always_ff @(posedge clk) begin
		io_rdata_q <= io_rdata;
		io_sel_q   <= io_hit;
	end

	assign mem_rdata = io_sel_q ? io_rdata_q : ram_rdata_a;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			mem_valid <= 1'b0;
		else
			mem_valid <= align_valid;
	end

	always_ff @(posedge clk) begin
		if (align_valid) begin
			mem.op       <= align.op;
			mem.byte_off <= align.byte_off;
			mem.rd       <= align.rd;
			mem.fault    <= align.fault;
		end
	end

	// Faulted access arrives with no lane enabled and writes nothing
	a_fault_no_write: assert property (@(posedge clk) disable iff (!rst_n)
		align_valid && align.fault |-> align.be == 4'b0000);

	// Both ports on the same byte of one word is outside the contract
	a_no_dual_write: assert property (@(posedge clk) disable iff (!rst_n)
		!(ram_we_a && con_we && ram_addr_a == con_req.addr &&
			|(align.be & con_req.be)));

endmodule

/* load_extend.sv */
`timescale 1ns/1ps

module load_extend (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      mem_valid,
	input  lsu_pkg::mem_stage_t       mem,
	input  logic [lsu_pkg::DATA_W-1:0] mem_rdata,
	output logic                      rsp_valid,
	output lsu_pkg::mem_rsp_t         rsp
);
	import lsu_pkg::*;

	logic [7:0]        lane_b;
	logic [15:0]       lane_h;
	logic [DATA_W-1:0] ext;
	logic              need_rsp;

	// Addressed byte and halfword of the read word
	always_comb begin
		unique case (mem.byte_off)
			2'd0: lane_b = mem_rdata[7:0];
			2'd1: lane_b = mem_rdata[15:8];
			2'd2: lane_b = mem_rdata[23:16];
			default: lane_b = mem_rdata[31:24];
		endcase
		lane_h = mem.byte_off[1] ? mem_rdata[31:16] : mem_rdata[15:0];
	end

	// Sign or zero extension by opcode
	always_comb begin
		unique case (mem.op)
			LB:  ext = {{24{lane_b[7]}}, lane_b};
			LBU: ext = {24'h0, lane_b};
			LH:  ext = {{16{lane_h[15]}}, lane_h};
			LHU: ext = {16'h0, lane_h};
			LW:  ext = mem_rdata;
			default: ext = '0;
		endcase
		// Faults return zero
		if (mem.fault)
			ext = '0;
	end

	// Stores answer only when they faulted
	assign need_rsp = mem.fault || !(mem.op inside {SB, SH, SW});

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rsp_valid <= 1'b0;
		else
			rsp_valid <= mem_valid && need_rsp;
	end

	// Last response held between pulses
	always_ff @(posedge clk) begin
		if (mem_valid) begin
			rsp.rdata <= ext;
			rsp.rd    <= mem.rd;
			rsp.fault <= mem.fault;
		end
	end

endmodule

/* dmem_subsys_top.sv */
`timescale 1ns/1ps

module dmem_subsys_top (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          req_en,
	input  lsu_pkg::mem_req_t             req,
	output logic                          rsp_valid,
	output lsu_pkg::mem_rsp_t             rsp,
	input  logic                          con_en,
	input  dmem_map_pkg::con_req_t        con_req,
	output logic [lsu_pkg::DATA_W-1:0]    con_rdata,
	input  logic [dmem_map_pkg::BTN_W-1:0] btn,
	input  logic [dmem_map_pkg::BTN_W-1:0] sw,
	output logic [dmem_map_pkg::LED_W-1:0] led
);
	import lsu_pkg::*;

	// Stage 1 to 2
	logic              align_valid;
	align_stage_t      align;
	// Stage 2 to 3
	logic              mem_valid;
	mem_stage_t        mem;
	logic [DATA_W-1:0] mem_rdata;

	store_align i_store_align (
		.clk         (clk),
		.rst_n       (rst_n),
		.req_en      (req_en),
		.req         (req),
		.align_valid (align_valid),
		.align       (align)
	);

	// Also serves the protocol controller and board I/O
	data_mem i_data_mem (
		.clk         (clk),
		.rst_n       (rst_n),
		.align_valid (align_valid),
		.align       (align),
		.btn         (btn),
		.sw          (sw),
		.con_en      (con_en),
		.con_req     (con_req),
		.con_rdata   (con_rdata),
		.mem_valid   (mem_valid),
		.mem         (mem),
		.mem_rdata   (mem_rdata),
		.led         (led)
	);

	load_extend i_load_extend (
		.clk       (clk),
		.rst_n     (rst_n),
		.mem_valid (mem_valid),
		.mem       (mem),
		.mem_rdata (mem_rdata),
		.rsp_valid (rsp_valid),
		.rsp       (rsp)
	);

endmodule

/* dmem_subsys_tb.sv */
`timescale 1ns/1ps

module dmem_subsys_tb;
	import lsu_pkg::*;
	import dmem_map_pkg::*;

	// Table entry kinds
	localparam logic [1:0] K_CORE = 2'd0;
	localparam logic [1:0] K_CON  = 2'd1;
	localparam logic [1:0] K_IDLE = 2'd2;
	localparam logic [1:0] K_BTN  = 2'd3;

	// One stimulus row, opbe is the opcode or the controller byte enables
	typedef struct packed {
		logic [1:0]  kind;
		logic [3:0]  opbe;
		logic [12:0] addr;
		logic        rnd;
		logic [31:0] data;
	} entry_t;

	logic        clk;
	logic        rst_n;
	logic        req_en;
	mem_req_t    req;
	logic        rsp_valid;
	mem_rsp_t    rsp;
	logic        con_en;
	con_req_t    con_req;
	logic [31:0] con_rdata;
	logic [3:0]  btn;
	logic [3:0]  sw;
	logic [3:0]  led;

	// Reference state
	logic [31:0] ram_m [1024];
	logic [31:0] led_m;
	logic [3:0]  btn_m;
	logic [3:0]  sw_m;
	logic [31:0] lfsr;

	entry_t      table_q[$];
	mem_rsp_t    exp_q[$];
	entry_t      e;
	logic [31:0] data;
	logic [31:0] exp_word;
	int          mismatch_count;
	int          other_count;

	dmem_subsys_top i_dmem_subsys_top (
		.clk       (clk),
		.rst_n     (rst_n),
		.req_en    (req_en),
		.req       (req),
		.rsp_valid (rsp_valid),
		.rsp       (rsp),
		.con_en    (con_en),
		.con_req   (con_req),
		.con_rdata (con_rdata),
		.btn       (btn),
		.sw        (sw),
		.led       (led)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Galois form, taps for x^32+x^22+x^2+x+1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
		return v;
	endfunction

	task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			mismatch_count++;
			$display("ERROR %0t ns: %s mismatch, got %0h expected %0h", $time, what, got, exp);
		end
	endtask

	// Word as the core sees it at a word address
	function automatic logic [31:0] read_word(input logic [10:0] wa);
		if (wa == IO_BTN_WA)
			return {28'h0, btn_m};
		if (wa == IO_SW_WA)
			return {28'h0, sw_m};
		if (wa == IO_LED_WA)
			return led_m;
		return ram_m[wa[9:0]];
	endfunction

	// Button and switch words ignore stores
	task automatic write_word(input logic [10:0] wa, input logic [31:0] w);
		if (wa == IO_LED_WA)
			led_m = w;
		else if (wa != IO_BTN_WA && wa != IO_SW_WA)
			ram_m[wa[9:0]] = w;
	endtask

	// Update the model and queue the response the core should get
	task automatic model_core(input mem_op_e op, input logic [12:0] addr,
			input logic [31:0] wdata, input logic [4:0] rd);
		int          size;
		logic        fault;
		logic [31:0] word;
		logic [31:0] val;
		mem_rsp_t    r;
		size  = (op inside {LB, LBU, SB}) ? 1 : ((op inside {LH, LHU, SH}) ? 2 : 4);
		fault = (size == 2 && addr[0]) || (size == 4 && addr[1:0] != 2'b00);
		word  = read_word(addr[12:2]);
		r.rd  = rd;
		r.fault = fault;
		r.rdata = '0;
		if (fault) begin
			exp_q.push_back(r);
		end else if (op inside {SB, SH, SW}) begin
			for (int b = 0; b < size; b++)
				word[8*(int'(addr[1:0])+b) +: 8] = wdata[8*b +: 8];
			write_word(addr[12:2], word);
		end else begin
			val = word >> (8*int'(addr[1:0]));
			case (op)
				LB:  r.rdata = {{24{val[7]}}, val[7:0]};
				LBU: r.rdata = {24'h0, val[7:0]};
				LH:  r.rdata = {{16{val[15]}}, val[15:0]};
				LHU: r.rdata = {16'h0, val[15:0]};
				default: r.rdata = val;
			endcase
			exp_q.push_back(r);
		end
	endtask

	// Idle until the pipeline is empty and every response is back
	task automatic wait_idle();
		int n;
		n = 0;
		while ((n < 4 || exp_q.size() != 0) && n < 40) begin
			@(negedge clk);
			req_en = 1'b0;
			con_en = 1'b0;
			n++;
		end
		if (exp_q.size() != 0) begin
			$display("Timeout: %0d expected load responses never arrived", exp_q.size());
			$display("Simulation failed");
			$finish;
		end
	endtask

	task automatic add_entry(input logic [1:0] kind, input logic [3:0] opbe,
			input logic [12:0] addr, input logic rnd, input logic [31:0] d);
		table_q.push_back('{kind, opbe, addr, rnd, d});
	endtask

	// Every load shape at every legal offset of one word
	task automatic add_load_sweep(input logic [12:0] base);
		add_entry(K_CORE, LW, base, 1'b0, 32'h0);
		for (int off = 0; off < 4; off += 2) begin
			add_entry(K_CORE, LH, base + 13'(off), 1'b0, 32'h0);
			add_entry(K_CORE, LHU, base + 13'(off), 1'b0, 32'h0);
		end
		for (int off = 0; off < 4; off++) begin
			add_entry(K_CORE, LB, base + 13'(off), 1'b0, 32'h0);
			add_entry(K_CORE, LBU, base + 13'(off), 1'b0, 32'h0);
		end
	endtask

	task automatic build_table();
		// Quiet after reset, LEDs dark
		add_entry(K_IDLE, 4'h0, 13'h000, 1'b0, 32'h0);
		// Word store, then halfword and byte merges
		add_entry(K_CORE, SW, 13'h040, 1'b1, 32'h0);
		add_load_sweep(13'h040);
		add_entry(K_CORE, SH, 13'h042, 1'b1, 32'h0);
		add_entry(K_CORE, SB, 13'h041, 1'b1, 32'h0);
		add_load_sweep(13'h040);
		// Sign bits set and clear in each lane
		add_entry(K_CORE, SW, 13'h080, 1'b0, 32'h80FF_7F01);
		add_load_sweep(13'h080);
		// Misaligned accesses, word must survive
		add_entry(K_CORE, SW, 13'h044, 1'b0, 32'h1234_5678);
		add_entry(K_CORE, SH, 13'h045, 1'b1, 32'h0);
		add_entry(K_CORE, SW, 13'h046, 1'b1, 32'h0);
		add_entry(K_CORE, LH, 13'h047, 1'b0, 32'h0);
		add_entry(K_CORE, LW, 13'h041, 1'b0, 32'h0);
		add_entry(K_CORE, LHU, 13'h043, 1'b0, 32'h0);
		add_entry(K_CORE, LW, 13'h044, 1'b0, 32'h0);
		add_entry(K_CORE, LW, 13'h040, 1'b0, 32'h0);
		// Store then load of the same word on the next cycle
		add_entry(K_CORE, SW, 13'h100, 1'b1, 32'h0);
		add_entry(K_CORE, LW, 13'h100, 1'b0, 32'h0);
		add_entry(K_CORE, SB, 13'h101, 1'b1, 32'h0);
		add_entry(K_CORE, LBU, 13'h101, 1'b0, 32'h0);
		add_entry(K_CORE, SH, 13'h102, 1'b1, 32'h0);
		add_entry(K_CORE, LH, 13'h102, 1'b0, 32'h0);
		add_entry(K_CORE, LW, 13'h100, 1'b0, 32'h0);
		// Unmapped word above I/O lands on RAM word 3
		add_entry(K_CORE, SW, 13'h100C, 1'b1, 32'h0);
		add_entry(K_CORE, LW, 13'h000C, 1'b0, 32'h0);
		// LED lanes
		add_entry(K_CORE, SW, 13'h1008, 1'b0, 32'h0000_0005);
		add_entry(K_IDLE, 4'h0, 13'h000, 1'b0, 32'h0);
		add_entry(K_CORE, SB, 13'h1008, 1'b0, 32'h0000_000A);
		add_entry(K_CORE, SB, 13'h1009, 1'b0, 32'h0000_003C);
		add_entry(K_CORE, LW, 13'h1008, 1'b0, 32'h0);
		add_entry(K_CORE, LBU, 13'h1009, 1'b0, 32'h0);
		add_entry(K_IDLE, 4'h0, 13'h000, 1'b0, 32'h0);
		// Buttons 6, switches 9
		add_entry(K_BTN, 4'h0, 13'h000, 1'b0, 32'h0000_0096);
		add_entry(K_CORE, LW, 13'h1000, 1'b0, 32'h0);
		add_entry(K_CORE, LW, 13'h1004, 1'b0, 32'h0);
		add_entry(K_CORE, LBU, 13'h1000, 1'b0, 32'h0);
		add_entry(K_CORE, LH, 13'h1004, 1'b0, 32'h0);
		// Controller writes seen by the core
		add_entry(K_CON, 4'hF, 13'h200, 1'b1, 32'h0);
		add_entry(K_CORE, LW, 13'h200, 1'b0, 32'h0);
		add_entry(K_CON, 4'h6, 13'h200, 1'b1, 32'h0);
		add_entry(K_CORE, LW, 13'h200, 1'b0, 32'h0);
		add_entry(K_CORE, LB, 13'h201, 1'b0, 32'h0);
		add_entry(K_CORE, LHU, 13'h202, 1'b0, 32'h0);
		add_entry(K_CON, 4'h0, 13'h200, 1'b0, 32'h0);
		// Core writes seen by the controller
		add_entry(K_CORE, SW, 13'h300, 1'b1, 32'h0);
		add_entry(K_CON, 4'h0, 13'h300, 1'b0, 32'h0);
		add_entry(K_CORE, SH, 13'h302, 1'b1, 32'h0);
		add_entry(K_CORE, SB, 13'h300, 1'b1, 32'h0);
		add_entry(K_CON, 4'h0, 13'h300, 1'b0, 32'h0);
		add_entry(K_CON, 4'h0, 13'h040, 1'b0, 32'h0);
	endtask

	// Responses matched in order on the falling edge
	always @(negedge clk) begin
		if (rst_n && rsp_valid) begin
			if (exp_q.size() == 0) begin
				other_count++;
				$display("Unexpected response at %0t ns with no load outstanding", $time);
			end else begin
				check("response", 64'(rsp), 64'(exp_q.pop_front()));
			end
		end
	end

	initial begin
		rst_n   = 1'b0;
		req_en  = 1'b0;
		req     = '0;
		con_en  = 1'b0;
		con_req = '0;
		btn     = 4'h5;
		sw      = 4'hC;
		btn_m   = 4'h5;
		sw_m    = 4'hC;
		led_m   = '0;
		lfsr    = 32'd58;
		mismatch_count = 0;
		other_count    = 0;
		build_table();
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		foreach (table_q[i]) begin
			e    = table_q[i];
			data = e.rnd ? rand_bits(32) : e.data;
			case (e.kind)
				K_CORE: begin
					@(negedge clk);
					req_en    = 1'b1;
					req.op    = mem_op_e'(e.opbe);
					req.addr  = e.addr;
					req.wdata = data;
					req.rd    = 5'(i);
					model_core(mem_op_e'(e.opbe), e.addr, data, 5'(i));
				end
				K_CON: begin
					// Core pipeline empty so the two ports never meet
					wait_idle();
					@(negedge clk);
					con_en        = 1'b1;
					con_req.be    = e.opbe;
					con_req.addr  = e.addr[11:2];
					con_req.wdata = data;
					exp_word      = ram_m[e.addr[11:2]];
					for (int b = 0; b < 4; b++) begin
						if (e.opbe[b])
							ram_m[e.addr[11:2]][8*b +: 8] = data[8*b +: 8];
					end
					@(negedge clk);
					con_en = 1'b0;
					if (e.opbe == 4'h0)
						check("con_rdata", 64'(con_rdata), 64'(exp_word));
				end
				K_IDLE: begin
					wait_idle();
					check("led", 64'(led), 64'(led_m[3:0]));
				end
				default: begin
					wait_idle();
					@(negedge clk);
					btn   = data[3:0];
					sw    = data[7:4];
					btn_m = data[3:0];
					sw_m  = data[7:4];
				end
			endcase
		end
		wait_idle();
		$display("Run finished with %0d value mismatches and %0d other errors",
			mismatch_count, other_count);
		if (mismatch_count == 0 && other_count == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* dmem_subsys_top.f */
lsu_pkg.sv
dmem_map_pkg.sv
store_align.sv
data_mem.sv
load_extend.sv
dmem_subsys_top.sv
dmem_subsys_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the data-memory subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
	--timescale 1ns/1ps \
	-f dmem_subsys_top.f \
	--top-module dmem_subsys_tb \
	-o sim_dmem

./obj_dir/sim_dmem > sim.log 2>&1
cat sim.log

# Verdict comes from the log
if grep -q "Simulation failed" sim.log; then
	echo "Test FAILED"
	exit 1
fi
echo "Test PASSED"
exit 0
